//--- flist.f
+incdir+.
axis_pkg.sv
router_csr_pkg.sv
port_echo_stage.sv
router_csr.sv
p4_echo_router.sv
tb_p4_echo_router.sv

//--- run.sh
#!/bin/sh
# Compile and run the echo router testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --timescale 1ns/100ps -f flist.f \
        --top-module tb_p4_echo_router --Mdir obj_dir -o sim_tb; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST RESULT: FAIL" "$log"; then
    echo "Simulation reported a failure, see $log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- tb_p4_echo_router.sv
/* Echo router testbench */

`include "router_macros.svh"

`timescale 1ns/100ps

module tb_p4_echo_router;

    typedef struct packed {
        logic       port;
        logic [3:0] len;
        logic       en;
    } stim_row_t;

    localparam int num_rows = 10;
    // Port 0 starts disabled, then both ports run with random back-pressure
    localparam stim_row_t stim_rows [num_rows] = '{
        '{1'b0, 4'd3, 1'b0}, '{1'b0, 4'd1, 1'b0}, '{1'b0, 4'd4, 1'b1}, '{1'b1, 4'd2, 1'b1},
        '{1'b1, 4'd5, 1'b1}, '{1'b0, 4'd1, 1'b1}, '{1'b1, 4'd1, 1'b1}, '{1'b0, 4'd6, 1'b1},
        '{1'b1, 4'd3, 1'b1}, '{1'b0, 4'd2, 1'b1}
    };

    logic                       phys_port_clk_ifc;
    logic                       rst;
    router_csr_pkg::apb_req_t   apb_req;
    router_csr_pkg::apb_rsp_t   apb_rsp;
    logic                       ing0_valid;
    axis_pkg::byte_beat_t       ing0_beat;
    logic                       ing0_ready;
    logic                       egr0_valid;
    axis_pkg::byte_beat_t       egr0_beat;
    logic                       egr0_ready;
    logic                       ing1_valid;
    axis_pkg::word_beat_t       ing1_beat;
    logic                       ing1_ready;
    logic                       egr1_valid;
    axis_pkg::word_beat_t       egr1_beat;
    logic                       egr1_ready;

    axis_pkg::byte_beat_t       exp0_q [$];
    axis_pkg::word_beat_t       exp1_q [$];
    axis_pkg::byte_beat_t       exp0_beat;
    axis_pkg::word_beat_t       exp1_beat;
    int                         frames_exp [`ROUTER_NUM_PORTS];

    p4_echo_router i_p4_echo_router (.*);

    initial phys_port_clk_ifc = 1'b0;
    always #20 phys_port_clk_ifc = ~phys_port_clk_ifc;

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte_beat(input string name, input axis_pkg::byte_beat_t exp,
                                   input axis_pkg::byte_beat_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_word_beat(input string name, input axis_pkg::word_beat_t exp,
                                   input axis_pkg::word_beat_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_csr_word(input string name, input router_csr_pkg::csr_word_t exp,
                                  input router_csr_pkg::csr_word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB master

    function automatic router_csr_pkg::apb_addr_t counter_addr(
        input router_csr_pkg::apb_addr_t base,
        input int                        port
    );
        return router_csr_pkg::apb_addr_t'(int'(base) + port * int'(`REG_PORT_STRIDE));
    endfunction

    task automatic apb_access(input logic write, input router_csr_pkg::apb_addr_t addr,
                              input router_csr_pkg::csr_word_t wdata,
                              output router_csr_pkg::apb_rsp_t rsp);
        router_csr_pkg::apb_req_t req;
        int                       wait_cycles;
        req = '0;
        req.sel = 1'b1;
        req.write = write;
        req.addr = addr;
        req.wdata = wdata;
        @(posedge phys_port_clk_ifc);
        apb_req <= req;
        // Ready belongs to the access cycle only
        @(negedge phys_port_clk_ifc);
        check_csr_word("APB ready in setup", '0,
                       router_csr_pkg::csr_word_t'(apb_rsp.ready));
        req.enable = 1'b1;
        @(posedge phys_port_clk_ifc);
        apb_req <= req;
        wait_cycles = 0;
        do begin
            @(negedge phys_port_clk_ifc);
            wait_cycles++;
            if (wait_cycles > 16) begin
                $display("APB ready never came for address %h", addr);
                stop_with_failure();
            end
        end while (!apb_rsp.ready);
        rsp = apb_rsp;
        @(posedge phys_port_clk_ifc);
        apb_req <= '0;
    endtask

    task automatic read_check(input string name, input router_csr_pkg::apb_addr_t addr,
                              input router_csr_pkg::csr_word_t exp);
        router_csr_pkg::apb_rsp_t rsp;
        apb_access(1'b0, addr, '0, rsp);
        check_csr_word(name, exp, rsp.rdata);
        check_csr_word({name, " slave error"}, '0, router_csr_pkg::csr_word_t'(rsp.slverr));
    endtask

    task automatic write_reg(input string name, input router_csr_pkg::apb_addr_t addr,
                             input router_csr_pkg::csr_word_t data, input logic exp_err);
        router_csr_pkg::apb_rsp_t rsp;
        apb_access(1'b1, addr, data, rsp);
        check_csr_word({name, " slave error"}, router_csr_pkg::csr_word_t'(exp_err),
                       router_csr_pkg::csr_word_t'(rsp.slverr));
    endtask

    // Both counters of a port track the frames sent while it was enabled
    task automatic check_counts(input int port);
        read_check($sformatf("ingress frames port %0d", port),
                   counter_addr(`REG_ING_FRAMES_BASE, port),
                   router_csr_pkg::csr_word_t'(frames_exp[port]));
        read_check($sformatf("egress frames port %0d", port),
                   counter_addr(`REG_EGR_FRAMES_BASE, port),
                   router_csr_pkg::csr_word_t'(frames_exp[port]));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sources and sinks

    task automatic send_frame(input logic port, input int len, input logic en);
        axis_pkg::byte_beat_t b;
        axis_pkg::word_beat_t w;
        int                   wait_cycles;
        for (int i = 0; i < len; i++) begin
            b.data = 8'($urandom);
            b.last = (i == len - 1);
            w.data = $urandom;
            w.keep = 4'($urandom);
            w.last = (i == len - 1);
            @(posedge phys_port_clk_ifc);
            if (port == 1'b0) begin
                ing0_valid <= 1'b1;
                ing0_beat <= b;
            end else begin
                ing1_valid <= 1'b1;
                ing1_beat <= w;
            end
            wait_cycles = 0;
            do begin
                @(negedge phys_port_clk_ifc);
                wait_cycles++;
                if (wait_cycles > 64) begin
                    $display("ingress ready stuck low on port %0d", port);
                    stop_with_failure();
                end
            end while (!(port ? ing1_ready : ing0_ready));
            // Beat transfers on the coming edge
            if (en && port == 1'b0) exp0_q.push_back(b);
            if (en && port == 1'b1) exp1_q.push_back(w);
        end
        @(posedge phys_port_clk_ifc);
        ing0_valid <= 1'b0;
        ing1_valid <= 1'b0;
    endtask

    task automatic check_no_egress(input logic port);
        for (int c = 0; c < 20; c++) begin
            @(negedge phys_port_clk_ifc);
            if (port ? egr1_valid : egr0_valid) begin
                $display("egress valid seen on disabled port %0d", port);
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_drain();
        int wait_cycles;
        wait_cycles = 0;
        do begin
            @(negedge phys_port_clk_ifc);
            wait_cycles++;
            if (wait_cycles > 200) begin
                $display("egress did not drain all recorded beats");
                stop_with_failure();
            end
        end while (exp0_q.size() != 0 || exp1_q.size() != 0 || egr0_valid || egr1_valid);
    endtask

    always @(posedge phys_port_clk_ifc) begin
        egr0_ready <= !rst && ($urandom % 4 != 0);
        egr1_ready <= !rst && ($urandom % 3 != 0);
    end

    always @(negedge phys_port_clk_ifc) begin
        if (!rst && egr0_valid && egr0_ready) begin
            if (exp0_q.size() == 0) begin
                $display("egress beat on port 0 with no ingress beat pending");
                stop_with_failure();
            end
            exp0_beat = exp0_q.pop_front();
            check_byte_beat("echo port 0", exp0_beat, egr0_beat);
        end
        if (!rst && egr1_valid && egr1_ready) begin
            if (exp1_q.size() == 0) begin
                $display("egress beat on port 1 with no ingress beat pending");
                stop_with_failure();
            end
            exp1_beat = exp1_q.pop_front();
            check_word_beat("echo port 1", exp1_beat, egr1_beat);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        router_csr_pkg::apb_rsp_t   rsp;
        router_csr_pkg::port_mask_t mask;
        stim_row_t                  row;
        void'($urandom(36047));
        rst <= 1'b1;
        apb_req <= '0;
        ing0_valid <= 1'b0;
        ing0_beat <= '0;
        ing1_valid <= 1'b0;
        ing1_beat <= '0;
        egr0_ready <= 1'b0;
        egr1_ready <= 1'b0;
        frames_exp[0] = 0;
        frames_exp[1] = 0;
        mask = '0;
        repeat (5) @(posedge phys_port_clk_ifc);
        rst <= 1'b0;

        read_check("reset port enable", `REG_PORT_ENABLE, '0);
        check_counts(0);
        check_counts(1);
        apb_access(1'b0, 8'hfc, '0, rsp);
        check_csr_word("unmapped read slave error", 32'd1,
                       router_csr_pkg::csr_word_t'(rsp.slverr));

        for (int i = 0; i < num_rows; i++) begin
            row = stim_rows[i];
            if (row.en != mask[row.port]) begin
                mask[row.port] = row.en;
                write_reg("port enable", `REG_PORT_ENABLE, 32'(mask), 1'b0);
            end
            send_frame(row.port, int'(row.len), row.en);
            if (row.en) begin
                frames_exp[row.port]++;
            end else begin
                check_no_egress(row.port);
                check_counts(int'(row.port));
            end
        end
        wait_drain();
        check_counts(0);
        check_counts(1);

        // Clear port 1 only
        write_reg("counter clear", `REG_CNT_CLEAR, 32'h2, 1'b0);
        frames_exp[1] = 0;
        check_counts(0);
        check_counts(1);
        read_check("counter clear readback", `REG_CNT_CLEAR, '0);
        write_reg("counter write", counter_addr(`REG_ING_FRAMES_BASE, 0), 32'ha5, 1'b1);
        check_counts(0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- p4_echo_router.sv
/* Two-port echo router */

`timescale 1ns/100ps

module p4_echo_router (
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst,

    input  router_csr_pkg::apb_req_t apb_req,
    output router_csr_pkg::apb_rsp_t apb_rsp,

    // Port 0 carries bytes
    input  logic                     ing0_valid,
    input  axis_pkg::byte_beat_t     ing0_beat,
    output logic                     ing0_ready,
    output logic                     egr0_valid,
    output axis_pkg::byte_beat_t     egr0_beat,
    input  logic                     egr0_ready,

    // Port 1 carries words
    input  logic                     ing1_valid,
    input  axis_pkg::word_beat_t     ing1_beat,
    output logic                     ing1_ready,
    output logic                     egr1_valid,
    output axis_pkg::word_beat_t     egr1_beat,
    input  logic                     egr1_ready
);

    router_csr_pkg::port_mask_t port_enable;
    router_csr_pkg::port_mask_t ing_frame;
    router_csr_pkg::port_mask_t egr_frame;

    //////////////////////////////////////////////////////////////////////
    // Echo paths

    port_echo_stage #(
        .beat_t ( axis_pkg::byte_beat_t )
    ) byte_echo (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .enable            ( port_enable[0]    ),
        .ing_valid         ( ing0_valid        ),
        .ing_beat          ( ing0_beat         ),
        .ing_ready         ( ing0_ready        ),
        .egr_valid         ( egr0_valid        ),
        .egr_beat          ( egr0_beat         ),
        .egr_ready         ( egr0_ready        ),
        .ing_frame         ( ing_frame[0]      ),
        .egr_frame         ( egr_frame[0]      )
    );

    port_echo_stage #(
        .beat_t ( axis_pkg::word_beat_t )
    ) word_echo (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .enable            ( port_enable[1]    ),
        .ing_valid         ( ing1_valid        ),
        .ing_beat          ( ing1_beat         ),
        .ing_ready         ( ing1_ready        ),
        .egr_valid         ( egr1_valid        ),
        .egr_beat          ( egr1_beat         ),
        .egr_ready         ( egr1_ready        ),
        .ing_frame         ( ing_frame[1]      ),
        .egr_frame         ( egr_frame[1]      )
    );

    //////////////////////////////////////////////////////////////////////
    // Control registers

    router_csr i_router_csr (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .apb_req           ( apb_req           ),
        .apb_rsp           ( apb_rsp           ),
        .ing_frame         ( ing_frame         ),
        .egr_frame         ( egr_frame         ),
        .port_enable       ( port_enable       )
    );

endmodule

//--- router_csr.sv
/* APB control and frame counters */

`include "router_macros.svh"

`timescale 1ns/100ps

module router_csr (
    input  logic                     phys_port_clk_ifc,
    input  logic                     rst,

    input  router_csr_pkg::apb_req_t apb_req,
    output router_csr_pkg::apb_rsp_t apb_rsp,

    input  router_csr_pkg::port_mask_t ing_frame,
    input  router_csr_pkg::port_mask_t egr_frame,
    output router_csr_pkg::port_mask_t port_enable
);

    logic                       access;
    logic                       wr_en;
    logic                       enable_hit;
    logic                       clear_hit;
    logic                       cnt_hit;
    router_csr_pkg::csr_word_t  rd_data;
    router_csr_pkg::port_mask_t cnt_clear;

    router_csr_pkg::frame_cnt_t ing_cnt [`ROUTER_NUM_PORTS];
    router_csr_pkg::frame_cnt_t egr_cnt [`ROUTER_NUM_PORTS];

    // Address of one counter of a given port
    function automatic router_csr_pkg::apb_addr_t cnt_addr(
        input router_csr_pkg::apb_addr_t base,
        input int                        port
    );
        return base + router_csr_pkg::apb_addr_t'(port) * `REG_PORT_STRIDE;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Access decode

    assign access     = apb_req.sel & apb_req.enable;
    assign wr_en      = access & apb_req.write;
    assign enable_hit = apb_req.addr == `REG_PORT_ENABLE;
    assign clear_hit  = apb_req.addr == `REG_CNT_CLEAR;

    // Clear pulses last only for the access cycle
    assign cnt_clear = (wr_en & clear_hit) ?
                       apb_req.wdata[`ROUTER_NUM_PORTS-1:0] : '0;

    //////////////////////////////////////////////////////////////////////
    // Port enables

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            port_enable <= '0;
        end else if (wr_en & enable_hit) begin
            port_enable <= apb_req.wdata[`ROUTER_NUM_PORTS-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame counters

    // Clear takes priority over a frame event on the same edge
    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                ing_cnt[p] <= '0;
                egr_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin
                    ing_cnt[p] <= '0;
                    egr_cnt[p] <= '0;
                end else begin
                    if (ing_frame[p]) begin
                        ing_cnt[p] <= ing_cnt[p] + router_csr_pkg::frame_cnt_t'(1);
                    end
                    if (egr_frame[p]) begin
                        egr_cnt[p] <= egr_cnt[p] + router_csr_pkg::frame_cnt_t'(1);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux

    // Clear register has no storage and reads back as zero
    always_comb begin
        rd_data = '0;
        cnt_hit = 1'b0;
        if (enable_hit) begin
            rd_data = router_csr_pkg::csr_word_t'(port_enable);
        end
        for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
            if (apb_req.addr == cnt_addr(`REG_ING_FRAMES_BASE, p)) begin
                cnt_hit = 1'b1;
                rd_data = router_csr_pkg::csr_word_t'(ing_cnt[p]);
            end
            if (apb_req.addr == cnt_addr(`REG_EGR_FRAMES_BASE, p)) begin
                cnt_hit = 1'b1;
                rd_data = router_csr_pkg::csr_word_t'(egr_cnt[p]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response

    // Counters are read only
    always_comb begin
        apb_rsp.ready  = access;
        apb_rsp.rdata  = (access & ~apb_req.write) ? rd_data : '0;
        apb_rsp.slverr = access & (~(enable_hit | clear_hit | cnt_hit) |
                                   (apb_req.write & cnt_hit));
    end

endmodule

//--- port_echo_stage.sv
/* One-slot echo stage */

`timescale 1ns/100ps

module port_echo_stage #(
    parameter type beat_t = axis_pkg::byte_beat_t
) (
    input  logic  phys_port_clk_ifc,
    input  logic  rst,
    input  logic  enable,

    input  logic  ing_valid,
    input  beat_t ing_beat,
    output logic  ing_ready,

    output logic  egr_valid,
    output beat_t egr_beat,
    input  logic  egr_ready,

    output logic  ing_frame,
    output logic  egr_frame
);

    logic accept;
    logic drain;

    //////////////////////////////////////////////////////////////////////
    // Handshake

    // Slot draining this edge frees room for the next beat
    assign drain     = egr_valid & egr_ready;
    assign ing_ready = ~enable | ~egr_valid | egr_ready;

    // Disabled port swallows beats without storing them
    assign accept    = ing_valid & ing_ready & enable;

    //////////////////////////////////////////////////////////////////////
    // Slot

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            egr_valid <= 1'b0;
        end else if (accept) begin
            egr_valid <= 1'b1;
        end else if (drain) begin
            egr_valid <= 1'b0;
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (accept) begin
            egr_beat <= ing_beat;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame events

    // End of frame seen on each side of the slot
    assign ing_frame = accept & ing_beat.last;
    assign egr_frame = drain & egr_beat.last;

endmodule

//--- router_csr_pkg.sv
/* Register block types */

`include "router_macros.svh"

package router_csr_pkg;

    typedef logic [`APB_ADDR_WIDTH-1:0]   apb_addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0]   csr_word_t;
    typedef logic [`ROUTER_CNT_WIDTH-1:0] frame_cnt_t;
    typedef logic [`ROUTER_NUM_PORTS-1:0] port_mask_t;

    //////////////////////////////////////////////////////////////////////
    // APB request from the master

    typedef struct packed {
        logic      sel;
        logic      enable;
        logic      write;
        apb_addr_t addr;
        csr_word_t wdata;
    } apb_req_t;

    //////////////////////////////////////////////////////////////////////
    // Zero wait state APB response

    typedef struct packed {
        csr_word_t rdata;
        logic      ready;
        logic      slverr;
    } apb_rsp_t;

endpackage

//--- axis_pkg.sv
/* Stream beat types */

package axis_pkg;

    //////////////////////////////////////////////////////////////////////
    // Port 0 carries one byte per beat

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    //////////////////////////////////////////////////////////////////////
    // Port 1 carries a 32-bit word per beat

    // Keep bit N marks data byte N as valid
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
    } word_beat_t;

endpackage

//--- router_macros.svh
/* Echo router constants */

`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Port and counter sizing

`define ROUTER_NUM_PORTS 2
`define ROUTER_CNT_WIDTH 32

//////////////////////////////////////////////////////////////////////
// APB bus widths

`define APB_ADDR_WIDTH 8
`define APB_DATA_WIDTH 32

//////////////////////////////////////////////////////////////////////
// Register map

`define REG_PORT_ENABLE     8'h00
`define REG_CNT_CLEAR       8'h04
// Counter pair of port N sits at base + N * stride
`define REG_ING_FRAMES_BASE 8'h10
`define REG_EGR_FRAMES_BASE 8'h14
`define REG_PORT_STRIDE     8'h08

`endif
